//--- source/switch_cfg.svh
`ifndef SWITCH_CFG_SVH
`define SWITCH_CFG_SVH

//////////////////////////////
// port side
//////////////////////////////

`define SW_PORTS 4 // source ports feeding this egress

//////////////////////////////
// packet format
//////////////////////////////

`define SW_WORD_W 32 // data word
`define SW_PRIO_W 3  // header priority, larger wins

// word count per packet, legal range 1..15
`define SW_LEN_W 4

//////////////////////////////
// queue sizing
//////////////////////////////

`define SW_DATA_DEPTH 32 // words per source port
`define SW_HDR_DEPTH  4  // headers per source port

`endif

//--- source/switch_pkg.sv
package switch_pkg;

`include "switch_cfg.svh"

    //////////////////////////////
    // basic fields
    //////////////////////////////

    typedef logic [`SW_WORD_W-1:0] word_t;
    typedef logic [$clog2(`SW_PORTS)-1:0] port_t;
    typedef logic [`SW_PRIO_W-1:0] prio_t;
    typedef logic [`SW_LEN_W-1:0] len_t;

    // header as written by the fabric, one entry per packet
    typedef struct packed {
        prio_t       prio;
        logic [31:0] crc;  // expected crc-32 over the data words
        len_t        len;  // data words in the packet
    } header_t;

    //////////////////////////////
    // scheduler
    //////////////////////////////

    typedef enum logic [2:0] {
        IDLE,  // wait for a packet and link ready
        GRANT, // arbitration result arrives
        HDR,   // header pop, counter load
        SEND,  // word pops
        DRAIN  // last word leaves the queue
    } sched_state_t;

endpackage

//--- source/port_queue.sv
`timescale 1ns/1ps

module port_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push && !full;  // writes to a full queue are dropped
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = mem[rd_ptr]; // oldest entry, seen before the pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            pop_data <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) begin
                rd_ptr   <= ptr_inc(rd_ptr);
                pop_data <= mem[rd_ptr]; // one cycle read latency
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/frame_word_counter.sv
`timescale 1ns/1ps

module frame_word_counter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  switch_pkg::len_t   load_len,
    input  logic               dec,
    output logic               last
);

    //////////////////////////////
    // words left in the packet
    //////////////////////////////

    switch_pkg::len_t remain;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
        end else if (load) begin
            remain <= load_len; // length from the popped header
        end else if (dec && remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    // next pop is the final one of the packet
    assign last = (remain == switch_pkg::len_t'(1));

endmodule

//--- source/priority_arbiter.sv
`timescale 1ns/1ps

`include "switch_cfg.svh"

module priority_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  arb_en,
    input  logic [`SW_PORTS-1:0]  req,
    input  switch_pkg::prio_t     prio [`SW_PORTS],
    input  logic                  select_scheme,
    output switch_pkg::port_t     grant,
    output logic                  grant_vld
);

    localparam int PORTS = `SW_PORTS;

    switch_pkg::port_t rr_ptr;  // first port searched in round robin
    switch_pkg::port_t fp_port;
    switch_pkg::port_t rr_port;
    switch_pkg::port_t pick;

    //////////////////////////////
    // fixed priority
    //////////////////////////////

    always_comb begin
        logic              found;
        switch_pkg::prio_t best;
        found   = 1'b0;
        best    = '0;
        fp_port = '0;
        for (int i = 0; i < PORTS; i++) begin
            // strict compare keeps the lower port on a tie
            if (req[i] && (!found || prio[i] > best)) begin
                found   = 1'b1;
                best    = prio[i];
                fp_port = switch_pkg::port_t'(i);
            end
        end
    end

    //////////////////////////////
    // round robin
    //////////////////////////////

    always_comb begin
        logic found;
        int   idx;
        found   = 1'b0;
        idx     = 0;
        rr_port = '0;
        for (int k = 0; k < PORTS; k++) begin
            idx = (int'(rr_ptr) + k) % PORTS; // wraps past the top port
            if (req[idx] && !found) begin
                found   = 1'b1;
                rr_port = switch_pkg::port_t'(idx);
            end
        end
    end

    assign pick = select_scheme ? rr_port : fp_port;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant     <= '0;
            grant_vld <= 1'b0;
            rr_ptr    <= '0;
        end else if (arb_en && |req) begin
            grant     <= pick;
            grant_vld <= 1'b1;
            rr_ptr    <= (pick == switch_pkg::port_t'(PORTS - 1)) ? '0 : pick + 1'b1;
        end else begin
            grant_vld <= 1'b0; // single cycle pulse
        end
    end

endmodule

//--- source/crc32_check.sv
`timescale 1ns/1ps

module crc32_check (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clr,
    input  logic               en,
    input  switch_pkg::word_t  data,
    output logic [31:0]        crc_next
);

    localparam logic [31:0] POLY = 32'h04C1_1DB7;

    logic [31:0] crc_acc;

    // one word through the shift register, msb first
    function automatic logic [31:0] crc_word(
        input logic [31:0]       crc_in,
        input switch_pkg::word_t word
    );
        logic [31:0] c;
        logic        fb;
        c = crc_in;
        for (int i = $bits(word) - 1; i >= 0; i--) begin
            fb = c[31] ^ word[i];
            c  = {c[30:0], 1'b0};
            if (fb) c = c ^ POLY;
        end
        return c;
    endfunction

    assign crc_next = crc_word(crc_acc, data); // includes the word on the bus now

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_acc <= '1;
        end else if (clr) begin
            crc_acc <= '1; // start of a new packet
        end else if (en) begin
            crc_acc <= crc_next;
        end
    end

endmodule

//--- source/egress_sched_fsm.sv
`timescale 1ns/1ps

module egress_sched_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 any_req,
    input  logic                 out_ready,
    input  switch_pkg::port_t    grant,
    input  logic                 grant_vld,
    input  logic                 cnt_last,
    input  switch_pkg::header_t  hdr_head,
    input  logic [31:0]          crc_next,
    output logic                 arb_en,
    output switch_pkg::port_t    sel_port,
    output logic                 hdr_pop,
    output logic                 data_pop,
    output logic                 cnt_load,
    output switch_pkg::len_t     cnt_len,
    output logic                 cnt_dec,
    output logic                 crc_clr,
    output logic                 out_vld,
    output logic                 out_sop,
    output logic                 out_eop,
    output logic                 out_err
);

    switch_pkg::sched_state_t state;
    switch_pkg::sched_state_t state_nxt;

    logic [31:0] exp_crc;    // crc from the header being sent
    logic        first_pend; // next pop carries sop
    logic        pipe_vld;
    logic        pipe_first;
    logic        pipe_last;

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            switch_pkg::IDLE: begin
                if (any_req && out_ready) state_nxt = switch_pkg::GRANT;
            end
            switch_pkg::GRANT: begin
                if (grant_vld) state_nxt = switch_pkg::HDR;
            end
            switch_pkg::HDR: state_nxt = switch_pkg::SEND;
            switch_pkg::SEND: begin
                if (data_pop && cnt_last) state_nxt = switch_pkg::DRAIN;
            end
            switch_pkg::DRAIN: state_nxt = switch_pkg::IDLE; // last word on the bus now
            default: state_nxt = switch_pkg::IDLE;
        endcase
    end

    //////////////////////////////
    // strobes
    //////////////////////////////

    assign arb_en   = (state == switch_pkg::IDLE) && any_req && out_ready;
    assign hdr_pop  = (state == switch_pkg::HDR);
    assign cnt_load = (state == switch_pkg::HDR);
    assign crc_clr  = (state == switch_pkg::HDR);
    assign cnt_len  = hdr_head.len;

    // no pop while the link holds off
    assign data_pop = (state == switch_pkg::SEND) && out_ready;
    assign cnt_dec  = data_pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= switch_pkg::IDLE;
            sel_port   <= '0;
            first_pend <= 1'b0;
            pipe_vld   <= 1'b0;
            pipe_first <= 1'b0;
            pipe_last  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == switch_pkg::GRANT && grant_vld) begin
                sel_port <= grant;
            end
            if (state == switch_pkg::HDR) begin
                first_pend <= 1'b1;
            end else if (data_pop) begin
                first_pend <= 1'b0;
            end
            // flags follow the pop by one cycle, like the queue data
            pipe_vld   <= data_pop;
            pipe_first <= data_pop && first_pend;
            pipe_last  <= data_pop && cnt_last;
        end
    end

    always_ff @(posedge clk) begin
        if (state == switch_pkg::HDR) begin
            exp_crc <= hdr_head.crc;
        end
    end

    assign out_vld = pipe_vld;
    assign out_sop = pipe_first;
    assign out_eop = pipe_last;
    assign out_err = pipe_last && (crc_next != exp_crc); // compare on the last word

endmodule

//--- source/egress_read_top.sv
`timescale 1ns/1ps

`include "switch_cfg.svh"

module egress_read_top (
    input  logic               clk,
    input  logic               rst_n,
    input  switch_pkg::port_t  in_port,
    input  logic               in_hdr_wr,
    input  switch_pkg::prio_t  in_prio,
    input  logic [31:0]        in_crc,
    input  switch_pkg::len_t   in_len,
    input  logic               in_data_wr,
    input  switch_pkg::word_t  in_data,
    input  logic               select_scheme,
    input  logic               out_ready,
    output switch_pkg::word_t  out_data,
    output logic               out_vld,
    output logic               out_sop,
    output logic               out_eop,
    output logic               out_err
);

    localparam int PORTS = `SW_PORTS;

    switch_pkg::header_t hdr_in;
    switch_pkg::header_t hdr_head_q [PORTS]; // head of each header queue
    switch_pkg::word_t   data_q_out [PORTS];
    switch_pkg::prio_t   head_prio [PORTS];
    logic [PORTS-1:0]    hdr_empty;
    switch_pkg::port_t   grant;
    switch_pkg::port_t   sel_port;
    switch_pkg::len_t    cnt_len;
    logic [31:0]         crc_next;
    logic                grant_vld;
    logic                arb_en;
    logic                hdr_pop;
    logic                data_pop;
    logic                cnt_load;
    logic                cnt_dec;
    logic                cnt_last;
    logic                crc_clr;

    assign hdr_in = '{prio: in_prio, crc: in_crc, len: in_len};

    //////////////////////////////
    // per port queue pairs
    //////////////////////////////

    for (genvar p = 0; p < PORTS; p++) begin : g_port
        port_queue #(
            .payload_t (switch_pkg::header_t),
            .DEPTH     (`SW_HDR_DEPTH)
        ) u_hdr_q (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (in_hdr_wr && in_port == switch_pkg::port_t'(p)),
            .push_data (hdr_in),
            .pop       (hdr_pop && sel_port == switch_pkg::port_t'(p)),
            .pop_data  (),
            .head      (hdr_head_q[p]),
            .empty     (hdr_empty[p]),
            .full      ()
        );

        port_queue #(
            .payload_t (switch_pkg::word_t),
            .DEPTH     (`SW_DATA_DEPTH)
        ) u_data_q (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (in_data_wr && in_port == switch_pkg::port_t'(p)),
            .push_data (in_data),
            .pop       (data_pop && sel_port == switch_pkg::port_t'(p)),
            .pop_data  (data_q_out[p]),
            .head      (),
            .empty     (),
            .full      ()
        );

        assign head_prio[p] = hdr_head_q[p].prio;
    end

    // sel_port holds through drain, so the last word still muxes out
    assign out_data = data_q_out[sel_port];

    priority_arbiter u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .arb_en        (arb_en),
        .req           (~hdr_empty), // a header means the whole packet is in
        .prio          (head_prio),
        .select_scheme (select_scheme),
        .grant         (grant),
        .grant_vld     (grant_vld)
    );

    frame_word_counter u_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (cnt_load),
        .load_len (cnt_len),
        .dec      (cnt_dec),
        .last     (cnt_last)
    );

    crc32_check u_crc (
        .clk      (clk),
        .rst_n    (rst_n),
        .clr      (crc_clr),
        .en       (out_vld),
        .data     (out_data),
        .crc_next (crc_next)
    );

    egress_sched_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .any_req   (~&hdr_empty),
        .out_ready (out_ready),
        .grant     (grant),
        .grant_vld (grant_vld),
        .cnt_last  (cnt_last),
        .hdr_head  (hdr_head_q[sel_port]),
        .crc_next  (crc_next),
        .arb_en    (arb_en),
        .sel_port  (sel_port),
        .hdr_pop   (hdr_pop),
        .data_pop  (data_pop),
        .cnt_load  (cnt_load),
        .cnt_len   (cnt_len),
        .cnt_dec   (cnt_dec),
        .crc_clr   (crc_clr),
        .out_vld   (out_vld),
        .out_sop   (out_sop),
        .out_eop   (out_eop),
        .out_err   (out_err)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,  // 10 ns clock
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- verification/egress_checker.sv
`timescale 1ns/1ps

module egress_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              out_ready,
    input  switch_pkg::word_t out_data,
    input  logic              out_vld,
    input  logic              out_sop,
    input  logic              out_eop,
    input  logic              out_err,
    output int                pkts_done,
    output int                data_errs,
    output int                frame_errs
);

    switch_pkg::word_t exp_words [$]; // all expected words, packet after packet
    int                exp_len [$];
    int                exp_port [$];
    bit                exp_err [$];

    logic ready_prev;  // out_ready one cycle back
    bit   in_pkt;
    int   cur_len;
    int   cur_port;
    bit   cur_err;
    int   word_idx;

    initial begin
        pkts_done  = 0;
        data_errs  = 0;
        frame_errs = 0;
        ready_prev = 1'b0;
        in_pkt     = 1'b0;
    end

    task automatic expect_word(input switch_pkg::word_t w);
        exp_words.push_back(w);
    endtask

    task automatic expect_packet(input int port, input int len, input bit err);
        exp_port.push_back(port);
        exp_len.push_back(len);
        exp_err.push_back(err);
    endtask

    // drop words of the current packet that never came out
    task automatic skip_rest();
        for (int i = word_idx; i < cur_len; i++) begin
            void'(exp_words.pop_front());
        end
        word_idx = cur_len;
    endtask

    //////////////////////////////
    // one valid word
    //////////////////////////////

    task automatic check_word();
        switch_pkg::word_t w;
        if (out_sop) begin
            if (in_pkt) begin
                $display("packet from port %0d got a new sop before its eop", cur_port);
                frame_errs++;
                skip_rest();
            end
            if (exp_len.size() == 0) begin
                $display("a packet started at %0t while none was expected", $time);
                frame_errs++;
                in_pkt = 1'b0;
                return;
            end
            cur_len  = exp_len.pop_front();
            cur_port = exp_port.pop_front();
            cur_err  = exp_err.pop_front();
            word_idx = 0;
            in_pkt   = 1'b1;
        end else if (!in_pkt) begin
            $display("a valid word at %0t came without a sop", $time);
            frame_errs++;
            return;
        end
        if (word_idx < cur_len) begin
            w = exp_words.pop_front();
            if (out_data !== w) begin
                $display("FAILED %0t: port %0d word %0d is %h, expected %h",
                         $time, cur_port, word_idx, out_data, w);
                data_errs++;
            end
        end else begin
            $display("packet from port %0d runs past %0d words without an eop",
                     cur_port, cur_len);
            frame_errs++;
        end
        word_idx++;
        if (out_eop) begin
            if (word_idx != cur_len) begin
                $display("FAILED %0t: port %0d packet has %0d words, expected %0d",
                         $time, cur_port, word_idx, cur_len);
                data_errs++;
                skip_rest();
            end
            if (out_err !== cur_err) begin
                $display("FAILED %0t: port %0d out_err is %b, expected %b",
                         $time, cur_port, out_err, cur_err);
                data_errs++;
            end
            pkts_done++;
            in_pkt = 1'b0;
        end else if (out_err) begin
            // error pulse belongs on the last word only
            $display("FAILED %0t: port %0d out_err is high on word %0d before the eop",
                     $time, cur_port, word_idx - 1);
            data_errs++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            ready_prev = 1'b0;
        end else begin
            if ((out_sop || out_eop || out_err) && !out_vld) begin
                $display("sop, eop or err strobe at %0t without a valid word", $time);
                frame_errs++;
            end
            // a pop needs out_ready, the word follows one cycle later
            if (out_vld && !ready_prev) begin
                $display("valid word at %0t more than one cycle after out_ready fell", $time);
                frame_errs++;
            end
            if (out_vld) check_word();
            ready_prev = out_ready;
        end
    end

endmodule

//--- verification/egress_tb.sv
`timescale 1ns/1ps

`include "switch_cfg.svh"

module egress_tb;

    localparam logic [31:0] SEED = 32'h1443_568a;
    localparam int PORTS          = `SW_PORTS;
    localparam int PKTS_PER_BATCH = PORTS; // at most one packet per port
    localparam int BATCHES        = 12;
    // 12 batches x 4 packets x (15 words + 6 overhead) x 4 for ready gaps
    localparam int TIMEOUT_CYCLES = 5000;

    logic              clk;
    logic              rst_n;
    switch_pkg::port_t in_port;
    logic              in_hdr_wr;
    switch_pkg::prio_t in_prio;
    logic [31:0]       in_crc;
    switch_pkg::len_t  in_len;
    logic              in_data_wr;
    switch_pkg::word_t in_data;
    logic              select_scheme;
    logic              out_ready;
    switch_pkg::word_t out_data;
    logic              out_vld;
    logic              out_sop;
    logic              out_eop;
    logic              out_err;
    int                pkts_done;
    int                data_errs;
    int                frame_errs;

    // reference model state
    int          cycles;
    int          total_pkts;
    int          rr_ptr;  // carried across batches
    bit          pend [PORTS];
    int          pkt_prio [PORTS];
    int          pkt_len [PORTS];
    bit          pkt_bad [PORTS];
    logic [31:0] pkt_words [PORTS][PKTS_PER_BATCH * 4];

    tb_clock_gen #(.HALF_PERIOD(5), .RESET_CYCLES(16)) u_clock (.clk(clk), .rst_n(rst_n));

    egress_read_top u_egress_read_top (
        .clk(clk), .rst_n(rst_n), .in_port(in_port), .in_hdr_wr(in_hdr_wr),
        .in_prio(in_prio), .in_crc(in_crc), .in_len(in_len), .in_data_wr(in_data_wr),
        .in_data(in_data), .select_scheme(select_scheme), .out_ready(out_ready),
        .out_data(out_data), .out_vld(out_vld), .out_sop(out_sop), .out_eop(out_eop),
        .out_err(out_err)
    );

    egress_checker u_checker (
        .clk(clk), .rst_n(rst_n), .out_ready(out_ready), .out_data(out_data),
        .out_vld(out_vld), .out_sop(out_sop), .out_eop(out_eop), .out_err(out_err),
        .pkts_done(pkts_done), .data_errs(data_errs), .frame_errs(frame_errs)
    );

    //////////////////////////////
    // model
    //////////////////////////////

    // crc-32, poly 04C11DB7, all ones start, msb first, no reflection
    function automatic logic [31:0] crc32_model(input int p);
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < pkt_len[p]; i++) begin
            for (int b = 31; b >= 0; b--) begin
                if (crc[31] ^ pkt_words[p][i][b]) crc = (crc << 1) ^ 32'h04C1_1DB7;
                else crc = crc << 1;
            end
        end
        return crc;
    endfunction

    function automatic int next_port(input bit rr);
        int best_p;
        int best_prio;
        int p;
        best_p    = -1;
        best_prio = -1;
        for (int k = 0; k < PORTS; k++) begin
            p = rr ? (rr_ptr + k) % PORTS : k;
            if (pend[p] && rr && best_p < 0) best_p = p;
            if (pend[p] && !rr && pkt_prio[p] > best_prio) begin // lower port wins ties
                best_p    = p;
                best_prio = pkt_prio[p];
            end
        end
        return best_p;
    endfunction

    // data words first, header last
    task automatic load_port(input int p);
        logic [31:0] crc;
        pkt_len[p]  = $urandom_range(15, 1);
        pkt_prio[p] = $urandom_range(7, 0);
        for (int i = 0; i < pkt_len[p]; i++) begin
            pkt_words[p][i] = $urandom;
            @(negedge clk);
            in_port    = switch_pkg::port_t'(p);
            in_data    = pkt_words[p][i];
            in_data_wr = 1'b1;
        end
        crc        = crc32_model(p);
        pkt_bad[p] = ($urandom_range(4, 0) == 0);
        if (pkt_bad[p]) crc = crc ^ (32'h1 << $urandom_range(31, 0));
        @(negedge clk);
        in_data_wr = 1'b0;
        in_hdr_wr  = 1'b1;
        in_prio    = switch_pkg::prio_t'(pkt_prio[p]);
        in_crc     = crc;
        in_len     = switch_pkg::len_t'(pkt_len[p]);
        @(negedge clk);
        in_hdr_wr = 1'b0;
        pend[p]   = 1'b1;
    endtask

    task automatic run_batch();
        int mask;
        int p;
        bit rr;
        mask = $urandom_range((1 << PORTS) - 1, 1);
        for (int k = 0; k < PORTS; k++) begin
            if (mask[k]) load_port(k);
        end
        rr = $urandom_range(1, 0);
        p  = next_port(rr);
        while (p >= 0) begin
            for (int i = 0; i < pkt_len[p]; i++) u_checker.expect_word(pkt_words[p][i]);
            u_checker.expect_packet(p, pkt_len[p], pkt_bad[p]);
            pend[p] = 1'b0;
            rr_ptr  = (p + 1) % PORTS; // pointer moves in both schemes
            total_pkts++;
            p = next_port(rr);
        end
        @(negedge clk);
        select_scheme = rr;
        out_ready     = 1'b1;
        while (pkts_done < total_pkts) begin
            @(negedge clk);
            if (out_ready) out_ready = ($urandom_range(7, 0) != 0); // short link gaps
            else out_ready = $urandom_range(1, 0);
        end
        out_ready = 1'b0;
    endtask

    initial begin
        in_port       = '0;
        in_hdr_wr     = 1'b0;
        in_prio       = '0;
        in_crc        = '0;
        in_len        = '0;
        in_data_wr    = 1'b0;
        in_data       = '0;
        select_scheme = 1'b0;
        out_ready     = 1'b0;
        total_pkts    = 0;
        rr_ptr        = 0;
        for (int k = 0; k < PORTS; k++) pend[k] = 1'b0;
        void'($urandom(SEED));
        @(posedge rst_n);
        repeat (4) @(negedge clk);
        for (int b = 0; b < BATCHES; b++) run_batch();
        repeat (10) @(negedge clk); // catch stray words
        $display("errors: data %0d, framing %0d, packets %0d of %0d",
                 data_errs, frame_errs, pkts_done, total_pkts);
        if (data_errs == 0 && frame_errs == 0 && pkts_done == total_pkts) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    //////////////////////////////
    // run limit
    //////////////////////////////

    initial cycles = 0;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d packets received",
                     cycles, pkts_done, total_pkts);
            $display("Test failed");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+source
source/switch_pkg.sv
source/port_queue.sv
source/frame_word_counter.sv
source/priority_arbiter.sv
source/crc32_check.sv
source/egress_sched_fsm.sv
source/egress_read_top.sv
verification/tb_clock_gen.sv
verification/egress_checker.sv
verification/egress_tb.sv
